// ==== spl_rx.f ====
+incdir+common
common/spl_code_pkg.sv
common/spl_pkt_pkg.sv
spl_receiver/spl_flit_decoder.sv
spl_receiver/spl_pkt_assembler.sv
verilog/spl_pkt_arbiter.sv
verilog/spl_rx_top.sv
testbench/spl_clk_gen.sv
testbench/spl_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the spl_rx testbench with Verilator
verilator --binary --timing --assert --top-module spl_rx_tb -f spl_rx.f > build.log 2>&1 \
  && ./obj_dir/Vspl_rx_tb > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

# verdict comes from the simulation log
grep -q "SIMULATION FAILED" sim.log \
  && { echo "simulation reported failure, see sim.log"; exit 1; } \
  || { echo "simulation finished without failures"; exit 0; }

// ==== testbench/spl_rx_tb.sv ====
`timescale 1ns/1ps
`include "spl_defs.svh"

module spl_rx_tb
  import spl_pkt_pkg::*;
;

  localparam int NUM_TESTS = 11;
  localparam int TIMEOUT   = NUM_TESTS * 19 * 40 + 500;
  localparam int F_NONE    = 0;
  localparam int F_PAR     = 1;
  localparam int F_BAD     = 2;
  // 2-of-7 codes for nibbles 0..f
  localparam logic [6:0] NIB_CODE [16] = '{
    7'b0010001, 7'b0010010, 7'b0010100, 7'b0011000,
    7'b0100001, 7'b0100010, 7'b0100100, 7'b0101000,
    7'b1000001, 7'b1000010, 7'b1000100, 7'b1001000,
    7'b0000011, 7'b0000110, 7'b0001100, 7'b0001001};
  localparam logic [6:0] EOP_CODE = 7'b1100000;
  // two-hot but outside the alphabet
  localparam logic [6:0] BAD_CODE = 7'b1010000;

  logic                                       tb_clk;
  logic                                       tb_rst;
  logic [`SPL_NUM_LINKS-1:0][`SPL_FLIT_W-1:0] link_data;
  logic [`SPL_NUM_LINKS-1:0]                  link_ack;
  logic                                       out_vld;
  spl_pkt_u                                   out_data;
  logic                                       out_link;
  logic                                       out_rdy;
  logic [`SPL_NUM_LINKS-1:0][`SPL_DROP_W-1:0] drop_cnt;

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  string       t_name [NUM_TESTS];
  int          t_link [NUM_TESTS];
  logic [1:0]  t_type [NUM_TESTS];
  logic [31:0] t_key [NUM_TESTS];
  logic [31:0] t_pld [NUM_TESTS];
  logic        t_has_pld [NUM_TESTS];
  int          t_fault [NUM_TESTS];
  int          n_loaded;
  // good entries per link in send order
  int          exp_idx0 [$];
  int          exp_idx1 [$];
  logic [7:0]  exp_drop [2];
  int          chk_pos [2];
  int          chk_pass;
  int          chk_err;
  int          main_err;
  int          cycle_cnt;
  logic [15:0] lfsr;

  spl_clk_gen u_clk (.tb_clk(tb_clk), .tb_rst(tb_rst));

  spl_rx_top DUT (.tb_clk(tb_clk), .tb_rst(tb_rst), .link_data(link_data),
    .link_ack(link_ack), .out_vld(out_vld), .out_data(out_data),
    .out_link(out_link), .out_rdy(out_rdy), .drop_cnt(drop_cnt));

  task automatic add_test(input string name, input int link, input logic [1:0] typ,
                          input logic [31:0] key, input logic [31:0] pld,
                          input logic has_pld, input int fault);
    t_name[n_loaded]    = name;
    t_link[n_loaded]    = link;
    t_type[n_loaded]    = typ;
    t_key[n_loaded]     = key;
    t_pld[n_loaded]     = pld;
    t_has_pld[n_loaded] = has_pld;
    t_fault[n_loaded]   = fault;
    if (fault != F_NONE)
      exp_drop[link] = exp_drop[link] + 8'd1;
    else if (link == 0)
      exp_idx0.push_back(n_loaded);
    else
      exp_idx1.push_back(n_loaded);
    n_loaded++;
  endtask

  // header with odd parity over all sent bits
  function automatic spl_hdr_t make_hdr(input int i);
    spl_hdr_t h;
    h.pkt_type = t_type[i];
    h.rsvd     = 4'h0;
    h.has_pld  = t_has_pld[i];
    h.parity   = 1'b0;
    h.parity   = ~((^{h, t_key[i]}) ^ (t_has_pld[i] & (^t_pld[i])));
    return h;
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // --------------------------------------------------
  // one NRZ sender per link
  // --------------------------------------------------
  for (genvar gl = 0; gl < `SPL_NUM_LINKS; gl++)
  begin : g_drv
    logic [6:0] wires;
    logic       link_done;
    int         n_pass;
    int         n_err;

    assign link_data[gl] = wires;

    // flip two wires and wait for the ack toggle
    task automatic send_flit(input logic [6:0] pat);
      logic prev;
      prev  = link_ack[gl];
      wires = wires ^ pat;
      do
      begin
        @(posedge tb_clk);
        #1;
      end
      while (link_ack[gl] == prev);
    endtask

    task automatic drive_link();
      spl_pkt_u   pkt;
      int         nibs;
      logic [7:0] drops;
      drops = 8'd0;
      for (int i = 0; i < NUM_TESTS; i++)
      begin
        if (t_link[i] == gl)
        begin
          pkt.f.hdr     = make_hdr(i);
          pkt.f.key     = t_key[i];
          pkt.f.payload = t_pld[i];
          if (t_fault[i] == F_PAR)
            pkt.f.hdr.parity = ~pkt.f.hdr.parity;
          nibs = t_has_pld[i] ? `SPL_LONG_NIBS : `SPL_SHORT_NIBS;
          for (int k = 0; k < nibs; k++)
          begin
            if (t_fault[i] == F_BAD && k == 4)
              send_flit(BAD_CODE);
            send_flit(NIB_CODE[pkt.nib[k]]);
          end
          send_flit(EOP_CODE);
          // counter moves on the same edge as the EOP ack
          if (t_fault[i] != F_NONE)
          begin
            drops = drops + 8'd1;
            if (drop_cnt[gl] != drops)
            begin
              $display("ERROR %s: drop_cnt expected %0d actual %0d", t_name[i], drops,
                       drop_cnt[gl]);
              n_err++;
            end
            else
            begin
              $display("PASS %s: dropped on link %0d", t_name[i], gl);
              n_pass++;
            end
          end
        end
      end
    endtask

    initial
    begin
      wires     = 7'h00;
      link_done = 1'b0;
      n_pass    = 0;
      n_err     = 0;
      @(negedge tb_rst);
      @(posedge tb_clk);
      #1;
      drive_link();
      link_done = 1'b1;
    end
  end

  // random back-pressure with one LFSR bit per cycle
  initial
  begin
    lfsr    = 16'd9831;
    out_rdy = 1'b0;
    @(negedge tb_rst);
    forever
    begin
      @(posedge tb_clk);
      #1;
      out_rdy = lfsr[0];
      lfsr    = lfsr_step(lfsr);
    end
  end

  // --------------------------------------------------
  // output checker sampled mid cycle
  // --------------------------------------------------
  task automatic check_output();
    int       i;
    spl_hdr_t eh;
    logic     ok;
    if ((out_link == 1'b0 && chk_pos[0] >= exp_idx0.size()) ||
        (out_link == 1'b1 && chk_pos[1] >= exp_idx1.size()))
    begin
      $display("unexpected packet on link %0d with key %h", out_link, out_data.f.key);
      chk_err++;
    end
    else
    begin
      i  = out_link ? exp_idx1[chk_pos[1]] : exp_idx0[chk_pos[0]];
      chk_pos[out_link] = chk_pos[out_link] + 1;
      ok = 1'b1;
      eh = make_hdr(i);
      if (out_data.f.hdr != eh)
      begin
        $display("ERROR %s: hdr expected %h actual %h", t_name[i], eh, out_data.f.hdr);
        ok = 1'b0;
      end
      if (out_data.f.key != t_key[i])
      begin
        $display("ERROR %s: key expected %h actual %h", t_name[i], t_key[i], out_data.f.key);
        ok = 1'b0;
      end
      // payload only exists with has_pld
      if (t_has_pld[i] && out_data.f.payload != t_pld[i])
      begin
        $display("ERROR %s: payload expected %h actual %h", t_name[i], t_pld[i],
                 out_data.f.payload);
        ok = 1'b0;
      end
      if (ok)
      begin
        $display("PASS %s: link %0d key %h", t_name[i], out_link, out_data.f.key);
        chk_pass++;
      end
      else
        chk_err++;
    end
  endtask

  always @(negedge tb_clk)
  begin
    if (!tb_rst && out_vld && out_rdy)
      check_output();
  end

  // run limit from table length
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT)
    begin
      @(posedge tb_clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT);
    $display("SIMULATION FAILED");
    $finish;
  end

  // --------------------------------------------------
  // table load and final report
  // --------------------------------------------------
  initial
  begin
    n_loaded = 0;
    exp_drop = '{8'd0, 8'd0};
    chk_pos  = '{0, 0};
    chk_pass = 0;
    chk_err  = 0;
    main_err = 0;
    add_test("short_a",  0, 2'd0, 32'h12345678, 32'h00000000, 1'b0, F_NONE);
    add_test("short_b",  0, 2'd1, 32'hdeadbeef, 32'h00000000, 1'b0, F_NONE);
    add_test("long_a",   0, 2'd0, 32'h0badf00d, 32'h55aa33cc, 1'b1, F_NONE);
    add_test("par_flip", 0, 2'd2, 32'h00ff00ff, 32'h00000000, 1'b0, F_PAR);
    add_test("bad_flit", 0, 2'd1, 32'hcafe0001, 32'h13579bdf, 1'b1, F_BAD);
    add_test("short_c",  0, 2'd2, 32'hffffffff, 32'h00000000, 1'b0, F_NONE);
    add_test("l1_short", 1, 2'd0, 32'h80000001, 32'h00000000, 1'b0, F_NONE);
    add_test("l1_long",  1, 2'd3, 32'h2468ace0, 32'hfedcba98, 1'b1, F_NONE);
    add_test("l1_par",   1, 2'd0, 32'h11112222, 32'h33334444, 1'b1, F_PAR);
    add_test("l1_bad",   1, 2'd1, 32'h0000beef, 32'h00000000, 1'b0, F_BAD);
    add_test("l1_tail",  1, 2'd3, 32'h7f7f7f7f, 32'h00000000, 1'b0, F_NONE);
    @(negedge tb_rst);
    // all sent and every good packet seen
    while (!(g_drv[0].link_done && g_drv[1].link_done &&
             chk_pos[0] == exp_idx0.size() && chk_pos[1] == exp_idx1.size()))
      @(posedge tb_clk);
    // idle time to catch duplicates
    repeat (60) @(posedge tb_clk);
    for (int k = 0; k < `SPL_NUM_LINKS; k++)
    begin
      if (drop_cnt[k] != exp_drop[k])
      begin
        $display("ERROR final_drops_link%0d: expected %0d actual %0d", k, exp_drop[k],
                 drop_cnt[k]);
        main_err++;
      end
    end
    $display("tests passed: %0d, errors: %0d",
             chk_pass + g_drv[0].n_pass + g_drv[1].n_pass,
             chk_err + main_err + g_drv[0].n_err + g_drv[1].n_err);
    if (chk_err + main_err + g_drv[0].n_err + g_drv[1].n_err == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== testbench/spl_clk_gen.sv ====
`timescale 1ns/1ps

module spl_clk_gen
(
  output logic tb_clk,
  output logic tb_rst
);

  // 8 ns period
  initial
  begin
    tb_clk = 1'b0;
    forever #4 tb_clk = ~tb_clk;
  end

  // reset held for 16 cycles and released just after an edge
  initial
  begin
    tb_rst = 1'b1;
    repeat (16) @(posedge tb_clk);
    #1 tb_rst = 1'b0;
  end

endmodule

// ==== verilog/spl_rx_top.sv ====
`timescale 1ns/1ps
`include "spl_defs.svh"

module spl_rx_top
  import spl_code_pkg::*;
  import spl_pkt_pkg::*;
(
  input  logic                                        tb_clk,
  input  logic                                        tb_rst,
  input  logic [`SPL_NUM_LINKS-1:0][`SPL_FLIT_W-1:0]  link_data,
  output logic [`SPL_NUM_LINKS-1:0]                   link_ack,
  output logic                                        out_vld,
  output spl_pkt_u                                    out_data,
  output logic                                        out_link,
  input  logic                                        out_rdy,
  output logic [`SPL_NUM_LINKS-1:0][`SPL_DROP_W-1:0]  drop_cnt
);

  // decoder to assembler per link
  logic [`SPL_NUM_LINKS-1:0]          sym_vld;
  logic [`SPL_NUM_LINKS-1:0]          sym_rdy;
  spl_sym_kind_t [`SPL_NUM_LINKS-1:0] sym_kind;
  logic [`SPL_NUM_LINKS-1:0][3:0]     sym_nib;
  // assembler to arbiter
  logic [`SPL_NUM_LINKS-1:0]          pkt_vld;
  logic [`SPL_NUM_LINKS-1:0]          pkt_rdy;
  spl_pkt_u [`SPL_NUM_LINKS-1:0]      pkt_data;

  // --------------------------------------------------
  // one receiver per link
  // --------------------------------------------------
  for (genvar i = 0; i < `SPL_NUM_LINKS; i++)
  begin : g_link
    spl_flit_decoder u_dec (.tb_clk(tb_clk), .tb_rst(tb_rst),
      .link_data(link_data[i]), .link_ack(link_ack[i]), .sym_vld(sym_vld[i]),
      .sym_kind(sym_kind[i]), .sym_nib(sym_nib[i]), .sym_rdy(sym_rdy[i]));

    spl_pkt_assembler u_asm (.tb_clk(tb_clk), .tb_rst(tb_rst),
      .sym_vld(sym_vld[i]), .sym_kind(sym_kind[i]), .sym_nib(sym_nib[i]),
      .sym_rdy(sym_rdy[i]), .pkt_vld(pkt_vld[i]), .pkt_data(pkt_data[i]),
      .pkt_rdy(pkt_rdy[i]), .drop_cnt(drop_cnt[i]));
  end

  // merge onto the shared output
  spl_pkt_arbiter u_arb (.tb_clk(tb_clk), .tb_rst(tb_rst), .in_vld(pkt_vld),
    .in_data(pkt_data), .in_rdy(pkt_rdy), .out_vld(out_vld),
    .out_data(out_data), .out_link(out_link), .out_rdy(out_rdy));

endmodule

// ==== verilog/spl_pkt_arbiter.sv ====
`timescale 1ns/1ps
`include "spl_defs.svh"

module spl_pkt_arbiter
  import spl_pkt_pkg::*;
(
  input  logic                          tb_clk,
  input  logic                          tb_rst,
  input  logic [`SPL_NUM_LINKS-1:0]     in_vld,
  input  spl_pkt_u [`SPL_NUM_LINKS-1:0] in_data,
  output logic [`SPL_NUM_LINKS-1:0]     in_rdy,
  output logic                          out_vld,
  output spl_pkt_u                      out_data,
  output logic                          out_link,
  input  logic                          out_rdy
);

  logic slot_free;
  logic contested;
  logic grant_any;
  logic grant_link;
  // loser of the last contested grant
  logic prio_link;

  // --------------------------------------------------
  // round robin grant
  // --------------------------------------------------
  // slot empty or draining this cycle
  assign slot_free  = !out_vld || out_rdy;
  assign contested  = &in_vld;
  assign grant_any  = |in_vld;
  assign grant_link = contested ? prio_link : in_vld[1];
  assign in_rdy[0]  = slot_free && grant_any && !grant_link;
  assign in_rdy[1]  = slot_free && grant_any && grant_link;

  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      out_vld   <= 1'b0;
      prio_link <= 1'b0;
    end
    else if (slot_free && grant_any)
    begin
      out_vld <= 1'b1;
      if (contested)
        prio_link <= ~grant_link;
    end
    else if (out_rdy)
      out_vld <= 1'b0;
  end

  // output slot payload and source tag
  always_ff @(posedge tb_clk)
  begin
    if (slot_free && grant_any)
    begin
      out_data <= in_data[grant_link];
      out_link <= grant_link;
    end
  end

  a_one_grant : assert property (@(posedge tb_clk) disable iff (tb_rst)
    !(in_rdy[0] && in_rdy[1]));

endmodule

// ==== spl_receiver/spl_pkt_assembler.sv ====
`timescale 1ns/1ps
`include "spl_defs.svh"

module spl_pkt_assembler
  import spl_code_pkg::*;
  import spl_pkt_pkg::*;
(
  input  logic                   tb_clk,
  input  logic                   tb_rst,
  input  logic                   sym_vld,
  input  spl_sym_kind_t          sym_kind,
  input  logic [3:0]             sym_nib,
  output logic                   sym_rdy,
  output logic                   pkt_vld,
  output spl_pkt_u               pkt_data,
  input  logic                   pkt_rdy,
  output logic [`SPL_DROP_W-1:0] drop_cnt
);

  localparam int CNT_W = $clog2(`SPL_LONG_NIBS + 1);

  // nibbles received so far
  logic [CNT_W-1:0] nib_cnt;
  // bad flit or overlong packet seen
  logic             damaged;
  spl_pkt_u         pkt_buf;
  logic             sym_acc;
  logic             room;
  logic             len_ok;
  logic             par_ok;
  logic             pkt_good;

  // stall the decoder while a packet waits
  assign sym_rdy  = !pkt_vld;
  assign sym_acc  = sym_vld && sym_rdy;
  assign pkt_data = pkt_buf;
  assign room     = (nib_cnt < CNT_W'(`SPL_LONG_NIBS));

  // --------------------------------------------------
  // end of packet checks
  // --------------------------------------------------
  // length must agree with has_pld
  assign len_ok = pkt_buf.f.hdr.has_pld ? (nib_cnt == CNT_W'(`SPL_LONG_NIBS))
                                        : (nib_cnt == CNT_W'(`SPL_SHORT_NIBS));
  // odd parity over the bits actually sent
  assign par_ok = (^{pkt_buf.f.hdr, pkt_buf.f.key})
                  ^ (pkt_buf.f.hdr.has_pld & (^pkt_buf.f.payload));
  assign pkt_good = len_ok && par_ok && !damaged;

  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      nib_cnt  <= '0;
      damaged  <= 1'b0;
      pkt_vld  <= 1'b0;
      drop_cnt <= '0;
    end
    else
    begin
      if (pkt_vld && pkt_rdy)
        pkt_vld <= 1'b0;
      if (sym_acc)
      begin
        case (sym_kind)
          SYM_DATA:
          begin
            if (room)
              nib_cnt <= nib_cnt + 1'b1;
            else
              damaged <= 1'b1;
          end
          SYM_EOP:
          begin
            nib_cnt <= '0;
            damaged <= 1'b0;
            if (pkt_good)
              pkt_vld <= 1'b1;
            else
              drop_cnt <= drop_cnt + 1'b1;
          end
          default: damaged <= 1'b1;
        endcase
      end
    end
  end

  // short packets leave the stale payload nibbles in place
  always_ff @(posedge tb_clk)
  begin
    if (sym_acc && (sym_kind == SYM_DATA) && room)
      pkt_buf.nib[nib_cnt] <= sym_nib;
  end

  a_pkt_hold : assert property (@(posedge tb_clk) disable iff (tb_rst)
    pkt_vld && !pkt_rdy |=> pkt_vld && $stable(pkt_data));

endmodule

// ==== spl_receiver/spl_flit_decoder.sv ====
`timescale 1ns/1ps
`include "spl_defs.svh"

module spl_flit_decoder
  import spl_code_pkg::*;
(
  input  logic                   tb_clk,
  input  logic                   tb_rst,
  input  logic [`SPL_FLIT_W-1:0] link_data,
  output logic                   link_ack,
  output logic                   sym_vld,
  output spl_sym_kind_t          sym_kind,
  output logic [3:0]             sym_nib,
  input  logic                   sym_rdy
);

  // two-flop synchroniser stages
  logic [`SPL_FLIT_W-1:0] sync_q1;
  logic [`SPL_FLIT_W-1:0] sync_q2;
  // wire state after the last accepted flit
  logic [`SPL_FLIT_W-1:0] last_wires;
  // changed wires of the flit being held
  logic [`SPL_FLIT_W-1:0] flit_pat;
  logic [`SPL_FLIT_W-1:0] diff;
  logic                   flit_seen;
  logic                   sym_acc;
  spl_sym_kind_t          dec_kind;
  logic [3:0]             dec_nib;

  // --------------------------------------------------
  // wire synchroniser
  // --------------------------------------------------
  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end
    else
    begin
      sync_q1 <= link_data;
      sync_q2 <= sync_q1;
    end
  end

  // in NRZ a flit is complete once two wires differ
  assign diff      = sync_q2 ^ last_wires;
  assign flit_seen = ($countones(diff) == 2);
  assign sym_acc   = sym_vld && sym_rdy;

  always_comb
  begin
    spl_decode_2of7(diff, dec_kind, dec_nib);
  end

  // --------------------------------------------------
  // symbol hold and ack toggle
  // --------------------------------------------------
  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      sym_vld    <= 1'b0;
      link_ack   <= 1'b0;
      last_wires <= '0;
    end
    else if (sym_acc)
    begin
      sym_vld    <= 1'b0;
      // sender may move on after this
      link_ack   <= ~link_ack;
      last_wires <= last_wires ^ flit_pat;
    end
    else if (!sym_vld && flit_seen)
      sym_vld <= 1'b1;
  end

  // decoded symbol frozen while held
  always_ff @(posedge tb_clk)
  begin
    if (!sym_vld && flit_seen)
    begin
      sym_kind <= dec_kind;
      sym_nib  <= dec_nib;
      flit_pat <= diff;
    end
  end

  a_sym_hold : assert property (@(posedge tb_clk) disable iff (tb_rst)
    sym_vld && !sym_rdy |=> sym_vld && $stable(sym_kind) && $stable(sym_nib));

endmodule

// ==== common/spl_pkt_pkg.sv ====
`include "spl_defs.svh"

package spl_pkt_pkg;

  // header byte with parity in bit 0
  typedef struct packed
  {
    logic [1:0] pkt_type;
    logic [3:0] rsvd;
    logic       has_pld;
    logic       parity;
  } spl_hdr_t;

  // field layout with the header in the lowest byte
  typedef struct packed
  {
    logic [31:0] payload;
    logic [31:0] key;
    spl_hdr_t    hdr;
  } spl_pkt_fields_t;

  // --------------------------------------------------
  // one 72-bit packet word seen as fields or as
  // the nibbles in link order (nibble 0 sent first)
  // --------------------------------------------------
  typedef union packed
  {
    spl_pkt_fields_t                    f;
    logic [`SPL_LONG_NIBS-1:0][3:0]     nib;
  } spl_pkt_u;

endpackage

// ==== common/spl_code_pkg.sv ====
`include "spl_defs.svh"

package spl_code_pkg;

  // what a completed 2-of-7 transition means
  typedef enum logic [1:0]
  {
    SYM_DATA = 2'd0,
    SYM_EOP  = 2'd1,
    SYM_BAD  = 2'd2
  } spl_sym_kind_t;

  // pattern holds the wires that changed
  function automatic void spl_decode_2of7(
    input  logic [`SPL_FLIT_W-1:0] pattern,
    output spl_sym_kind_t          kind,
    output logic [3:0]             nib
  );
    kind = SYM_DATA;
    nib  = 4'h0;
    case (pattern)
      7'b0010001: nib = 4'h0;
      7'b0010010: nib = 4'h1;
      7'b0010100: nib = 4'h2;
      7'b0011000: nib = 4'h3;
      7'b0100001: nib = 4'h4;
      7'b0100010: nib = 4'h5;
      7'b0100100: nib = 4'h6;
      7'b0101000: nib = 4'h7;
      7'b1000001: nib = 4'h8;
      7'b1000010: nib = 4'h9;
      7'b1000100: nib = 4'ha;
      7'b1001000: nib = 4'hb;
      7'b0000011: nib = 4'hc;
      7'b0000110: nib = 4'hd;
      7'b0001100: nib = 4'he;
      7'b0001001: nib = 4'hf;
      7'b1100000: kind = SYM_EOP;
      // remaining two-hot codes are not in the alphabet
      default:    kind = SYM_BAD;
    endcase
  endfunction

endpackage

// ==== common/spl_defs.svh ====
`ifndef SPL_DEFS_SVH
`define SPL_DEFS_SVH

// --------------------------------------------------
// link receiver subsystem sizes
// --------------------------------------------------

// number of peer link receivers
`define SPL_NUM_LINKS 2

// data wires per link
`define SPL_FLIT_W 7

// nibbles in a packet without payload
`define SPL_SHORT_NIBS 10

// nibbles in a packet with payload
`define SPL_LONG_NIBS 18

// per link dropped packet counter
`define SPL_DROP_W 8

`endif
